// File: src/spi_io_pkg.sv
`default_nettype none

package spi_io_pkg;

    // --------------------------------------------------
    // Buffer geometry
    // --------------------------------------------------
    localparam int BUF_DEPTH = 16;                     // Bytes per buffer, TX and RX alike
    localparam int BUF_AW    = $clog2(BUF_DEPTH);      // Buffer address width
    localparam int CNT_W     = $clog2(BUF_DEPTH + 1);  // Byte count width, holds 0..16

    // --------------------------------------------------
    // Host request and per-byte command
    // --------------------------------------------------
    // Captured on send, then counted down by the transfer FSM
    typedef struct packed {
        logic [CNT_W-1:0] tx_count;   // Bytes to shift out first
        logic [CNT_W-1:0] rx_count;   // Bytes to shift in afterwards
    } xfer_req_t;

    // One byte handed to the bit engine
    typedef struct packed {
        logic [7:0] data;             // Ignored when rx_phase is set
        logic       rx_phase;         // mosi held low, received byte kept
    } spi_cmd_t;

    // --------------------------------------------------
    // State encodings
    // --------------------------------------------------
    typedef enum logic [2:0] {
        IDLE,       // Waiting for send
        SELECT,     // cs low, half period before the first byte
        SEND,       // Transmit byte in flight
        GAP,        // Idle SPI periods between bytes
        RECEIVE,    // Receive byte in flight
        FINISH      // Half period before cs rises
    } xfer_state_e;

    typedef enum logic [1:0] {
        S_IDLE,     // sclk low, clock generator off
        S_SHIFT,    // Bits 7 down to 1
        S_LAST      // Bit 0, ends on the eighth fall
    } shift_state_e;

endpackage

`default_nettype wire

// File: src/spi_clock_gen.sv
`default_nettype none
`timescale 1ns/1ps

module spi_clock_gen #(
    parameter int CLK_DIV = 2              // sysClk cycles per half SPI period
) (
    input  logic sysClk,
    input  logic reset,
    input  logic enable,                   // High while a byte is shifting
    output logic rise,                     // One-cycle strobe, sclk goes high
    output logic fall                      // One-cycle strobe, sclk goes low
);

    localparam int            CW   = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
    localparam logic [CW-1:0] LAST = CW'(CLK_DIV - 1);

    logic [CW-1:0] div_cnt;                // Cycles into the current half period
    logic          phase;                  // 0 in low half, 1 in high half
    logic          tick;                   // End of a half period

    // Strobes alternate, rise comes first after enable
    assign tick = enable && (div_cnt == LAST);
    assign rise = tick && !phase;
    assign fall = tick && phase;

    // --------------------------------------------------
    // Divider
    // --------------------------------------------------
    // Dropping enable restarts on a clean phase for the next byte
    always_ff @(posedge sysClk) begin
        if (!reset || !enable) begin
            div_cnt <= '0;
            phase   <= 1'b0;
        end else if (tick) begin
            div_cnt <= '0;
            phase   <= ~phase;                 // Next strobe is the other edge
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: src/spi_master.sv
`default_nettype none
`timescale 1ns/1ps

module spi_master #(
    parameter int CLK_DIV = 2                  // sysClk cycles per half SPI period
) (
    input  logic                 sysClk,
    input  logic                 reset,
    input  logic                 start,        // One-cycle pulse, master must be idle
    input  spi_io_pkg::spi_cmd_t cmd,          // Valid with start
    output logic                 byte_done,    // Pulse on the eighth fall
    output logic [7:0]           rx_data,      // Valid on the byte_done cycle
    output logic                 sclk,
    output logic                 mosi,
    input  logic                 miso
);

    import spi_io_pkg::*;

    shift_state_e state;
    logic [2:0]   bit_cnt;                     // Falls seen so far in this byte
    logic [7:0]   tx_shift;                    // MSB drives mosi
    logic [7:0]   rx_shift;                    // miso enters at the LSB
    logic         load;
    logic         enable;
    logic         rise;
    logic         fall;

    assign load      = start && (state == S_IDLE);
    assign enable    = (state != S_IDLE);      // Clock runs only while shifting
    assign byte_done = fall && (state == S_LAST);
    assign mosi      = tx_shift[7];
    assign rx_data   = rx_shift;

    spi_clock_gen #(
        .CLK_DIV (CLK_DIV)
    ) u_clock_gen (
        .sysClk  (sysClk),
        .reset   (reset),
        .enable  (enable),
        .rise    (rise),
        .fall    (fall)
    );

    // --------------------------------------------------
    // Bit sequencing
    // --------------------------------------------------
    always_ff @(posedge sysClk) begin
        if (!reset) begin
            state   <= S_IDLE;
            bit_cnt <= '0;
        end else begin
            unique case (state)
                S_IDLE: begin
                    if (load) begin
                        state   <= S_SHIFT;
                        bit_cnt <= '0;
                    end
                end
                S_SHIFT: begin
                    if (fall) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd6)   // Seventh fall, bit 0 now on mosi
                            state <= S_LAST;
                    end
                end
                S_LAST: begin
                    if (fall)
                        state <= S_IDLE;       // Drops enable next cycle
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Mode 0, sclk idles low
    always_ff @(posedge sysClk) begin
        if (!reset)
            sclk <= 1'b0;
        else if (rise)
            sclk <= 1'b1;
        else if (fall)
            sclk <= 1'b0;
    end

    // Transmit side, zero fill leaves mosi low after the byte
    always_ff @(posedge sysClk) begin
        if (!reset)
            tx_shift <= '0;
        else if (load)
            tx_shift <= cmd.rx_phase ? 8'h00 : cmd.data;
        else if (fall)
            tx_shift <= {tx_shift[6:0], 1'b0};  // Next bit out on the falling edge
    end

    // Receive side, sampled at the rising edge
    always_ff @(posedge sysClk) begin
        if (rise)
            rx_shift <= {rx_shift[6:0], miso};
    end

endmodule

`default_nettype wire

// File: src/io_transfer.sv
`default_nettype none
`timescale 1ns/1ps

module io_transfer #(
    parameter int CLK_DIV  = 2,                // sysClk cycles per half SPI period
    parameter int GAP_CLKS = 2                 // Idle SPI periods between bytes
) (
    input  logic                  sysClk,
    input  logic                  reset,
    input  logic                  send,        // Active low, honored only while idle
    input  spi_io_pkg::xfer_req_t req,
    input  logic                  tx_wr,       // Active low write strobe
    input  logic [7:0]            tx_byte,
    input  logic [3:0]            rx_index,
    output logic [7:0]            rx_byte,
    output logic                  busy,
    output logic                  done,
    output logic                  cs,
    output logic                  sclk,
    output logic                  mosi,
    input  logic                  miso
);

    import spi_io_pkg::*;

    localparam int GAP_CYC = GAP_CLKS * 2 * CLK_DIV;      // Gap length in sysClk cycles
    localparam int TW      = $clog2(GAP_CYC + CLK_DIV + 1);

    logic [7:0]        tx_buf [BUF_DEPTH];
    logic [7:0]        rx_buf [BUF_DEPTH];
    logic [BUF_AW-1:0] tx_wptr;                // Host write position
    logic [BUF_AW-1:0] tx_rptr;                // Next byte to send
    logic [BUF_AW-1:0] rx_wptr;                // Next receive slot

    xfer_state_e       state;
    xfer_req_t         remain;                 // Bytes still to start
    logic [TW-1:0]     timer;                  // Half period and gap delay
    logic              start;
    logic              byte_done;
    logic [7:0]        rx_data;
    spi_cmd_t          cmd;
    logic              next_tx;
    logic              last_byte;

    // --------------------------------------------------
    // Byte issue
    // --------------------------------------------------
    assign start     = ((state == SELECT) || (state == GAP)) && (timer == '0);
    assign next_tx   = (remain.tx_count != '0);              // Transmit bytes go first
    assign last_byte = (remain.tx_count == '0) && (remain.rx_count == '0);

    always_comb begin
        cmd.data     = tx_buf[tx_rptr];
        cmd.rx_phase = !next_tx;
    end

    assign busy    = (state != IDLE);
    assign rx_byte = rx_buf[rx_index];         // Host read, combinational

    spi_master #(
        .CLK_DIV   (CLK_DIV)
    ) u_spi_master (
        .sysClk    (sysClk),
        .reset     (reset),
        .start     (start),
        .cmd       (cmd),
        .byte_done (byte_done),
        .rx_data   (rx_data),
        .sclk      (sclk),
        .mosi      (mosi),
        .miso      (miso)
    );

    // --------------------------------------------------
    // Buffers
    // --------------------------------------------------
    always_ff @(posedge sysClk) begin
        if (!reset || state == FINISH)
            tx_wptr <= '0;                     // Each transaction loads from zero
        else if (!tx_wr)
            tx_wptr <= tx_wptr + 1'b1;
    end

    always_ff @(posedge sysClk) begin
        if (!tx_wr)
            tx_buf[tx_wptr] <= tx_byte;
    end

    // Receive byte k lands at address k
    always_ff @(posedge sysClk) begin
        if (byte_done && state == RECEIVE)
            rx_buf[rx_wptr] <= rx_data;
    end

    // --------------------------------------------------
    // Transaction FSM
    // --------------------------------------------------
    always_ff @(posedge sysClk) begin
        if (!reset) begin
            state   <= IDLE;
            remain  <= '0;
            timer   <= '0;
            cs      <= 1'b1;
            done    <= 1'b0;
            tx_rptr <= '0;
            rx_wptr <= '0;
        end else begin
            done <= 1'b0;                      // Single-cycle pulse
            unique case (state)
                IDLE: begin
                    if (!send) begin
                        remain <= req;
                        if (req.tx_count == '0 && req.rx_count == '0) begin
                            state <= FINISH;   // Nothing to do, cs stays high
                            timer <= '0;
                        end else begin
                            state <= SELECT;
                            timer <= TW'(CLK_DIV);
                            cs    <= 1'b0;
                        end
                    end
                end
                SELECT, GAP: begin
                    if (timer == '0) begin     // start pulses this cycle
                        if (next_tx) begin
                            state           <= SEND;
                            remain.tx_count <= remain.tx_count - 1'b1;
                            tx_rptr         <= tx_rptr + 1'b1;
                        end else begin
                            state           <= RECEIVE;
                            remain.rx_count <= remain.rx_count - 1'b1;
                        end
                    end else begin
                        timer <= timer - 1'b1;
                    end
                end
                SEND, RECEIVE: begin
                    if (byte_done) begin
                        if (state == RECEIVE)
                            rx_wptr <= rx_wptr + 1'b1;
                        if (last_byte) begin
                            state <= FINISH;
                            timer <= TW'(CLK_DIV - 1);   // Half period before cs rises
                        end else begin
                            state <= GAP;
                            timer <= TW'(GAP_CYC - 1);
                        end
                    end
                end
                FINISH: begin
                    tx_rptr <= '0;
                    rx_wptr <= '0;
                    if (timer == '0) begin
                        state <= IDLE;
                        cs    <= 1'b1;
                        done  <= 1'b1;         // Same cycle busy goes low
                    end else begin
                        timer <= timer - 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/spi_io_top.sv
`default_nettype none
`timescale 1ns/1ps

// SPI transfer engine, mode 0, one slave
// Transaction length varies with the request, done marks the end
module spi_io_top #(
    parameter int CLK_DIV  = 2,                // sysClk cycles per half SPI period
    parameter int GAP_CLKS = 2                 // Idle SPI periods between bytes
) (
    input  logic                  sysClk,
    input  logic                  reset,       // Synchronous, active low
    input  logic                  send,        // Active low strobe
    input  spi_io_pkg::xfer_req_t req,
    input  logic                  tx_wr,       // Active low strobe
    input  logic [7:0]            tx_byte,
    input  logic [3:0]            rx_index,
    output logic [7:0]            rx_byte,
    output logic                  busy,
    output logic                  done,
    output logic                  sclk,
    output logic                  mosi,
    input  logic                  miso,
    output logic                  cs           // Active low chip select
);

    io_transfer #(
        .CLK_DIV  (CLK_DIV),
        .GAP_CLKS (GAP_CLKS)
    ) u_io_transfer (
        .sysClk   (sysClk),
        .reset    (reset),
        .send     (send),
        .req      (req),
        .tx_wr    (tx_wr),
        .tx_byte  (tx_byte),
        .rx_index (rx_index),
        .rx_byte  (rx_byte),
        .busy     (busy),
        .done     (done),
        .cs       (cs),
        .sclk     (sclk),
        .mosi     (mosi),
        .miso     (miso)
    );

endmodule

`default_nettype wire

// File: bench/spi_slave_model.sv
`default_nettype none
`timescale 1ns/1ps

module spi_slave_model (
    input  logic       sclk,
    input  logic       cs,
    input  logic       mosi,
    input  logic [4:0] tx_bytes,           // Bytes the master sends before it reads
    output logic       miso,
    output logic [7:0] captured [32],      // mosi bytes of the last transaction
    output int         byte_count,         // Bytes seen since cs fell
    output int         rx_mosi_high        // mosi high bits during receive bytes
);

    logic       cs_q;
    logic       sclk_q;
    logic [7:0] shift_in;
    logic [7:0] answer;                    // Byte being shifted out on miso
    logic [7:0] first_byte;                // First byte captured in this transaction
    int         bit_idx;

    // Receive byte j answers j ^ 5A ^ first captured byte
    function automatic logic [7:0] reply_for(int k);
        if (k < int'(tx_bytes))
            return 8'hFF;                  // Transmit phase, master ignores miso
        return 8'(k - int'(tx_bytes)) ^ 8'h5A ^ first_byte;
    endfunction

    // --------------------------------------------------
    // Mode 0 slave, sample on rise, shift on fall
    // --------------------------------------------------
    initial begin
        miso         = 1'b0;
        byte_count   = 0;
        rx_mosi_high = 0;
        cs_q         = 1'b1;
        sclk_q       = 1'b0;
        bit_idx      = 0;
        shift_in     = 8'h00;
        answer       = 8'h00;
        first_byte   = 8'h00;
        forever begin
            @(cs or sclk);
            if (cs_q && !cs) begin                 // New transaction
                bit_idx      = 0;
                byte_count   = 0;
                rx_mosi_high = 0;
                first_byte   = 8'h00;
                answer       = reply_for(0);
                miso         = answer[7];          // MSB ready before the first rise
            end else if (!cs && !sclk_q && sclk) begin
                shift_in = {shift_in[6:0], mosi};
                if (byte_count >= int'(tx_bytes) && mosi)
                    rx_mosi_high++;
                bit_idx++;
                if (bit_idx == 8) begin
                    if (byte_count < 32)
                        captured[5'(byte_count)] = shift_in;
                    if (byte_count == 0)
                        first_byte = shift_in;
                    byte_count++;
                    bit_idx = 0;
                end
            end else if (!cs && sclk_q && !sclk) begin
                if (bit_idx == 0)
                    answer = reply_for(byte_count);   // Byte boundary
                miso = answer[3'(7 - bit_idx)];
            end
            cs_q   = cs;
            sclk_q = sclk;
        end
    end

endmodule

`default_nettype wire

// File: bench/spi_io_assert.sv
`default_nettype none
`timescale 1ns/1ps

module spi_io_assert (
    input logic sysClk,
    input logic reset,
    input logic cs,
    input logic sclk,
    input logic busy,
    input logic done
);

    int fail_count = 0;                    // Failed assertions so far

    // Mode 0 clock idles low while the slave is deselected
    sclk_low_when_deselected: assert property (
        @(posedge sysClk) disable iff (!reset) cs |-> !sclk
    ) else begin
        $error("sclk high while cs is high");
        fail_count++;
    end

    // No select outside a transaction
    cs_high_when_idle: assert property (
        @(posedge sysClk) disable iff (!reset) !busy |-> cs
    ) else begin
        $error("cs low while busy is low");
        fail_count++;
    end

    // done closes a transaction that was running
    done_after_busy: assert property (
        @(posedge sysClk) disable iff (!reset) done |-> $past(busy)
    ) else begin
        $error("done without busy in the previous cycle");
        fail_count++;
    end

endmodule

`default_nettype wire

// File: bench/tb_spi_io.sv
`default_nettype none
`timescale 1ns/1ps

module tb_spi_io;

    import spi_io_pkg::*;

    localparam int CLK_DIV   = 2;
    localparam int GAP_CLKS  = 2;
    localparam int NUM_CASES = 5;

    // One table row
    typedef struct packed {
        logic [4:0] n;                     // Transmit bytes
        logic [4:0] m;                     // Receive bytes
        logic [7:0] base;                  // Data is base plus index
        logic       rnd;                   // Random data instead
    } case_t;

    logic       sysClk;
    logic       reset;
    logic       send;
    xfer_req_t  req;
    logic       tx_wr;
    logic [7:0] tx_byte;
    logic [3:0] rx_index;
    logic [7:0] rx_byte;
    logic       busy;
    logic       done;
    logic       sclk;
    logic       mosi;
    logic       miso;
    logic       cs;
    logic [4:0] slave_tx_bytes;
    logic [7:0] captured [32];
    int         byte_count;
    int         rx_mosi_high;

    case_t      cases [NUM_CASES];
    logic [7:0] tx_data [BUF_DEPTH];       // Bytes loaded for the current case
    integer     seed;
    int         errors;
    int         checks;
    int         case_errors;
    longint     watchdog_ns;
    logic       table_ready;

    spi_io_top #(.CLK_DIV(CLK_DIV), .GAP_CLKS(GAP_CLKS)) DUT (
        .sysClk(sysClk), .reset(reset), .send(send), .req(req),
        .tx_wr(tx_wr), .tx_byte(tx_byte), .rx_index(rx_index), .rx_byte(rx_byte),
        .busy(busy), .done(done), .sclk(sclk), .mosi(mosi), .miso(miso), .cs(cs)
    );

    spi_slave_model slave (
        .sclk(sclk), .cs(cs), .mosi(mosi), .tx_bytes(slave_tx_bytes), .miso(miso),
        .captured(captured), .byte_count(byte_count), .rx_mosi_high(rx_mosi_high)
    );

    bind spi_io_top spi_io_assert u_assert (
        .sysClk(sysClk), .reset(reset), .cs(cs), .sclk(sclk), .busy(busy), .done(done)
    );

    initial begin
        sysClk = 1'b0;
        forever #50 sysClk = ~sysClk;      // 100 ns period
    end

    // Watchdog, budget follows from the table
    initial begin
        wait (table_ready);
        #(watchdog_ns);
        $display("Timeout: run still going after %0d ns", watchdog_ns);
        $display(">>> FAIL");
        $finish;
    end

    // --------------------------------------------------
    // Checks and expected values
    // --------------------------------------------------
    task automatic expect_value(input string name, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            $display("error: %s = %h, expected %h", name, got, exp);
            errors++;
            case_errors++;
        end
    endtask

    task automatic expect_true(input bit cond, input string what);
        checks++;
        assert (cond) else begin
            $display("%s", what);
            errors++;
            case_errors++;
        end
    endtask

    // Rising edges from the send drive edge to the done edge
    function automatic int expected_cycles(int n, int m);
        int bytes;
        bytes = n + m;
        if (bytes == 0)
            return 2;
        return 2 + 2 * CLK_DIV + bytes * 16 * CLK_DIV + (bytes - 1) * GAP_CLKS * 2 * CLK_DIV;
    endfunction

    function automatic logic [7:0] reply_byte(int j, logic [7:0] first);
        return 8'(j) ^ 8'h5A ^ first;
    endfunction

    task automatic fill_table;
        cases[0] = '{n: 5'd4,  m: 5'd0,  base: 8'h10, rnd: 1'b0};   // Transmit only
        cases[1] = '{n: 5'd2,  m: 5'd5,  base: 8'hA0, rnd: 1'b0};   // Pointer back at zero
        cases[2] = '{n: 5'd0,  m: 5'd0,  base: 8'h00, rnd: 1'b0};   // Empty request
        cases[3] = '{n: 5'd1,  m: 5'd3,  base: 8'h7E, rnd: 1'b0};
        cases[4] = '{n: 5'd16, m: 5'd16, base: 8'h00, rnd: 1'b1};   // Full buffers
    endtask

    task automatic load_buffer(input int n);
        int i;
        for (i = 0; i < n; i++) begin
            @(posedge sysClk);
            #5;
            tx_wr   = 1'b0;
            tx_byte = tx_data[4'(i)];
        end
        @(posedge sysClk);
        #5;
        tx_wr = 1'b1;
    endtask

    // --------------------------------------------------
    // One transaction
    // --------------------------------------------------
    task automatic run_case(input int idx);
        case_t      c;
        int         n;
        int         m;
        int         i;
        int         edges;
        int         limit;
        integer     rnd_word;
        bit         cs_fell;
        logic [7:0] first;
        c = cases[idx];
        n = int'(c.n);
        m = int'(c.m);
        case_errors = 0;
        for (i = 0; i < BUF_DEPTH; i++) begin
            if (c.rnd) begin
                rnd_word = $random(seed);
                tx_data[4'(i)] = rnd_word[7:0];
            end else begin
                tx_data[4'(i)] = c.base + 8'(i);
            end
        end
        slave_tx_bytes = c.n;
        load_buffer(n);
        @(posedge sysClk);
        #5;
        send        = 1'b0;
        req.tx_count = c.n;
        req.rx_count = c.m;
        edges   = 0;
        cs_fell = 1'b0;
        limit   = 2 * expected_cycles(n, m) + 20;
        while (edges < limit) begin
            @(posedge sysClk);
            edges++;
            if (edges == 1) begin
                #5;
                send = 1'b1;               // One-cycle strobe
            end
            @(negedge sysClk);
            if (!cs)
                cs_fell = 1'b1;
            if (done)
                break;
        end
        expect_true(done === 1'b1, $sformatf("case %0d: done never arrived", idx + 1));
        expect_value("done latency", edges, expected_cycles(n, m));
        expect_value("cs", int'(cs), 1);
        expect_value("busy", int'(busy), 0);
        @(negedge sysClk);
        expect_value("done", int'(done), 0);   // Single pulse
        if (n + m == 0) begin
            expect_true(!cs_fell, $sformatf("case %0d: cs fell on an empty request", idx + 1));
        end else begin
            expect_value("slave byte count", byte_count, n + m);
            for (i = 0; i < n; i++)
                expect_value($sformatf("mosi byte %0d", i), int'(captured[5'(i)]),
                             int'(tx_data[4'(i)]));
            expect_value("mosi high bits in receive", rx_mosi_high, 0);
            first = (n > 0) ? tx_data[0] : 8'h00;
            for (i = 0; i < m; i++) begin
                @(posedge sysClk);
                #5;
                rx_index = 4'(i);
                @(negedge sysClk);
                expect_value($sformatf("rx_byte[%0d]", i), int'(rx_byte),
                             int'(reply_byte(i, first)));
            end
        end
        $display("case %0d N=%0d M=%0d done, errors %0d", idx + 1, n, m, case_errors);
    endtask

    initial begin
        int k;
        reset          = 1'b0;
        send           = 1'b1;
        tx_wr          = 1'b1;
        tx_byte        = 8'h00;
        req            = '0;
        rx_index       = 4'h0;
        slave_tx_bytes = 5'd0;
        seed           = 32'ha4a8;
        errors         = 0;
        checks         = 0;
        case_errors    = 0;
        table_ready    = 1'b0;
        fill_table();
        watchdog_ns = 0;
        for (k = 0; k < NUM_CASES; k++)
            watchdog_ns += longint'((int'(cases[k].n) + int'(cases[k].m) + 2)
                                    * (16 + 2 * GAP_CLKS) * CLK_DIV * 100);
        watchdog_ns = watchdog_ns * 3 / 2;     // 50 percent margin
        table_ready = 1'b1;
        repeat (8) @(posedge sysClk);
        #5;
        reset = 1'b1;
        @(negedge sysClk);                     // Idle outputs before any send
        expect_value("cs", int'(cs), 1);
        expect_value("sclk", int'(sclk), 0);
        expect_value("mosi", int'(mosi), 0);
        expect_value("busy", int'(busy), 0);
        expect_value("done", int'(done), 0);
        $display("reset state done, errors %0d", case_errors);
        for (k = 0; k < NUM_CASES; k++)
            run_case(k);
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, DUT.u_assert.fail_count);
        if (errors == 0 && DUT.u_assert.fail_count == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
src/spi_io_pkg.sv
src/spi_clock_gen.sv
src/spi_master.sv
src/io_transfer.sv
src/spi_io_top.sv
bench/spi_slave_model.sv
bench/spi_io_assert.sv
bench/tb_spi_io.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_spi_io
FILELIST = all.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = >>> PASS

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Keep running after an assertion error so the testbench can report the result
run: compile
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	@grep -q -- "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
